//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_timer_unit
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
STIM      ?= timer_stim.txt

SOURCES := timer_config.svh timer_pkg.sv timer_channel.sv timer_regs.sv \
           timer_unit.sv tb_timer_unit.sv
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) $(STIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+.
timer_pkg.sv
timer_channel.sv
timer_regs.sv
timer_unit.sv
tb_timer_unit.sv

//--- tb_timer_unit.sv
`timescale 1ns/1ps
`include "timer_config.svh"

module tb_timer_unit;

   typedef enum logic [3:0] {
      OP_WRITE, OP_READ, OP_IDLE, OP_EVENT, OP_IRQ_WAIT, OP_IRQ_PERIOD,
      OP_READ_MAX, OP_READ_MIN, OP_READ_SAME, OP_READ_LESS, OP_BUSY, OP_NO_IRQ
   } stim_op_e;

   localparam int CLK_PERIOD = 8;

   logic                     clk = 1'b0;
   logic                     rst_n;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   logic [`TIMER_ADDR_W-1:0] wb_adr;
   logic [`TIMER_DATA_W-1:0] wb_dat_w;
   logic [`TIMER_SEL_W-1:0]  wb_sel;
   logic [`TIMER_DATA_W-1:0] wb_dat_r;
   logic                     wb_ack;
   logic                     event_lo;
   logic                     event_hi;
   logic                     irq_lo;
   logic                     irq_hi;
   logic                     busy;

   stim_op_e                 op_q[$];
   logic [31:0]              adr_q[$];
   logic [31:0]              dat_q[$];
   logic [31:0]              exp_q[$];
   integer                   seed = 32'h8d82;
   longint                   budget_ns = 0;

   timer_unit dut (
      .clk_i      (clk),
      .rst_ni     (rst_n),
      .wb_cyc_i   (wb_cyc),
      .wb_stb_i   (wb_stb),
      .wb_we_i    (wb_we),
      .wb_adr_i   (wb_adr),
      .wb_dat_i   (wb_dat_w),
      .wb_sel_i   (wb_sel),
      .wb_dat_o   (wb_dat_r),
      .wb_ack_o   (wb_ack),
      .event_lo_i (event_lo),
      .event_hi_i (event_hi),
      .irq_lo_o   (irq_lo),
      .irq_hi_o   (irq_hi),
      .busy_o     (busy)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ************************************************************
   // helpers
   // ************************************************************

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "run aborted");
   endtask

   task automatic check_result(input string name, input logic [31:0] expv,
                               input logic [31:0] actv, input bit ok);
      assert (ok)
      else
      begin
         $display("ERROR %s: expected %h, actual %h", name, expv, actv);
         $display("*** FAILED ***");
         $fatal(1, "check %s failed", name);
      end
   endtask

   task automatic load_stim();
      int          fd;
      int          n;
      int          op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] e;
      string       line;
      fd = $fopen("timer_stim.txt", "r");
      assert (fd != 0) else abort_run("cannot open timer_stim.txt");
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line[0] == "#")
            continue;                            // comment or empty line
         n = $sscanf(line, "%h %h %h %h", op, a, d, e);
         assert (n == 4 && op <= OP_NO_IRQ) else abort_run({"malformed stim line: ", line});
         op_q.push_back(stim_op_e'(op));
         adr_q.push_back(a);
         dat_q.push_back(d);
         exp_q.push_back(e);
      end
      $fclose(fd);
   endtask

   // worst case length of the whole file in cycles
   function automatic longint budget_cycles();
      longint total;
      total = 32;                                // reset and wrap up
      foreach (op_q[i])
      begin
         total += 24;                            // gap, access and ack
         case (op_q[i])
            OP_IDLE, OP_IRQ_WAIT, OP_NO_IRQ: total += dat_q[i];
            OP_IRQ_PERIOD:                   total += 4 * exp_q[i];
            default:                         ;
         endcase
      end
      return total;
   endfunction

   // one wishbone classic access that starts and ends on a falling edge
   task automatic bus_access(input logic we, input logic [31:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
      int gap;
      int waited;
      gap = $random(seed) & 3;
      repeat (gap) @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr[`TIMER_ADDR_W-1:0];
      wb_dat_w = wdat;
      waited   = 0;
      do
      begin
         @(negedge clk);
         waited++;
         assert (waited < 16) else abort_run("no wishbone ack within 16 cycles");
      end
      while (!wb_ack);
      rdat   = wb_dat_r;
      wb_cyc = 1'b0;                             // drop the request right after ack
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic pulse_event(input logic which);
      if (which)
         event_hi = 1'b1;
      else
         event_lo = 1'b1;
      @(negedge clk);
      event_lo = 1'b0;
      event_hi = 1'b0;
   endtask

   task automatic wait_irq(input logic which, input int limit, input string name);
      int n;
      n = 0;
      while (!(which ? irq_hi : irq_lo))
      begin
         @(negedge clk);
         n++;
         assert (n <= limit) else abort_run($sformatf("%s: no irq within %0d cycles", name, limit));
      end
   endtask

   // ************************************************************
   // stimulus interpreter
   // ************************************************************

   initial
   begin
      wait (budget_ns != 0);
      #(budget_ns);
      $display("watchdog: simulation did not finish within %0d ns", budget_ns);
      $display("*** FAILED ***");
      $fatal(1, "timeout");
   end

   initial
   begin
      logic [31:0] rd;
      logic [31:0] last;
      logic        irq;
      int          n;
      string       name;
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = '1;                             // full words only
      event_lo = 1'b0;
      event_hi = 1'b0;
      last     = '0;
      load_stim();
      budget_ns = budget_cycles() * CLK_PERIOD;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // ack, both irqs and busy come out of reset low
      check_result("reset state", 32'h0, {28'b0, wb_ack, irq_lo, irq_hi, busy},
                   {wb_ack, irq_lo, irq_hi, busy} == 4'b0000);

      foreach (op_q[i])
      begin
         name = $sformatf("cmd %0d %s", i, op_q[i].name());
         case (op_q[i])
            OP_WRITE:    bus_access(1'b1, adr_q[i], dat_q[i], rd);
            OP_IDLE:     repeat (dat_q[i]) @(negedge clk);
            OP_EVENT:    pulse_event(adr_q[i][0]);
            OP_IRQ_WAIT: wait_irq(adr_q[i][0], dat_q[i], name);
            OP_BUSY:     check_result(name, exp_q[i], {31'b0, busy}, busy == exp_q[i][0]);
            OP_IRQ_PERIOD:
            begin
               wait_irq(adr_q[i][0], 2 * exp_q[i], name);
               n = 0;
               do
               begin
                  @(negedge clk);
                  n++;
               end
               while (!(adr_q[i][0] ? irq_hi : irq_lo) && n < 2 * exp_q[i]);
               check_result(name, exp_q[i], 32'(n), n == exp_q[i]);
            end
            OP_NO_IRQ:
               repeat (dat_q[i])
               begin
                  @(negedge clk);
                  irq = adr_q[i][0] ? irq_hi : irq_lo;
                  check_result(name, 32'h0, {31'b0, irq}, !irq);
               end
            default:
            begin
               bus_access(1'b0, adr_q[i], 32'h0, rd);
               case (op_q[i])
                  OP_READ:      check_result(name, exp_q[i], rd, rd == exp_q[i]);
                  OP_READ_MAX:  check_result(name, exp_q[i], rd, rd <= exp_q[i]);
                  OP_READ_MIN:  check_result(name, exp_q[i], rd, rd >= exp_q[i]);
                  OP_READ_SAME: check_result(name, last, rd, rd == last);
                  default:      check_result(name, last, rd, rd < last);
               endcase
               last = rd;                        // reference for the next compare
            end
         endcase
      end

      @(negedge clk);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- timer_channel.sv
`timescale 1ns/1ps
`include "timer_config.svh"

module timer_channel
   import timer_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_ni,
   input  chan_ctrl_t ctrl_i,
   output chan_stat_t stat_o
);

   logic [`TIMER_PRESC_W-1:0] presc_q;
   logic [`TIMER_PRESC_W-1:0] presc_d;
   logic [`TIMER_DATA_W-1:0]  count_q;
   logic [`TIMER_DATA_W-1:0]  count_d;
   logic                      presc_wrap;
   logic                      tick;
   logic                      match;

   // ************************************************************
   // tick generation
   // ************************************************************

   // >= also catches a reload value lowered below the running count
   assign presc_wrap = (presc_q >= ctrl_i.cfg.presc_val);

   // without prescaler the counter advances every cycle
   assign tick  = ctrl_i.cfg.enable & (~ctrl_i.cfg.presc_en | presc_wrap);
   assign match = tick & (count_q == ctrl_i.cmp);

   always_comb
   begin
      presc_d = presc_q;
      if (ctrl_i.restart)
         presc_d = '0;
      else if (!ctrl_i.cfg.presc_en)
         presc_d = '0;                      // next enable starts a full period
      else if (ctrl_i.cfg.enable)
      begin
         if (presc_wrap)
            presc_d = '0;
         else
            presc_d = presc_q + 1'b1;
      end
   end

   // ************************************************************
   // counter
   // ************************************************************

   // restart beats load, load beats counting
   always_comb
   begin
      count_d = count_q;
      if (ctrl_i.restart)
         count_d = '0;
      else if (ctrl_i.load)
         count_d = ctrl_i.load_val;
      else if (tick)
      begin
         if (match && ctrl_i.cfg.cmp_clr)
            count_d = '0;                   // compare and clear
         else
            count_d = count_q + 1'b1;       // equals cmp+1 on a plain match
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         presc_q <= '0;
         count_q <= '0;
      end
      else
      begin
         presc_q <= presc_d;
         count_q <= count_d;
      end
   end

   // match stays combinational so irq and one-shot see it in the tick cycle
   assign stat_o = '{count: count_q, match: match};

endmodule

//--- timer_config.svh
`ifndef TIMER_CONFIG_SVH
`define TIMER_CONFIG_SVH

// ************************************************************
// timer peripheral widths
// ************************************************************

// data bus and counter width
`define TIMER_DATA_W 32

// register address, byte granular, word aligned registers
`define TIMER_ADDR_W 6

// prescaler reload value
`define TIMER_PRESC_W 8

// bytes per data word, one select line each
`define TIMER_SEL_W (`TIMER_DATA_W / 8)

`endif

//--- timer_pkg.sv
package timer_pkg;

`include "timer_config.svh"

   // register map in byte addresses
   typedef enum logic [`TIMER_ADDR_W-1:0] {
      CFG_LO   = 6'h00,
      CFG_HI   = 6'h04,
      VAL_LO   = 6'h08,
      VAL_HI   = 6'h0C,
      CMP_LO   = 6'h10,
      CMP_HI   = 6'h14,
      START_LO = 6'h18,
      START_HI = 6'h1C,
      RESET_LO = 6'h20,
      RESET_HI = 6'h24
   } reg_addr_e;

   typedef enum logic {
      ACK_IDLE,
      ACK_DONE
   } ack_state_e;

   // one channel's configuration word
   typedef struct packed {
      logic [15:0]               rsvd_hi;
      logic [`TIMER_PRESC_W-1:0] presc_val;
      logic                      rsvd_7;    // always reads zero
      logic                      presc_en;
      logic                      one_shot;
      logic                      cmp_clr;
      logic                      event_en;
      logic                      irq_en;
      logic                      clear;     // self-clearing
      logic                      enable;
   } timer_cfg_t;

   typedef struct packed {
      timer_cfg_t               cfg;
      logic [`TIMER_DATA_W-1:0] cmp;
      logic                     load;      // strobe
      logic [`TIMER_DATA_W-1:0] load_val;
      logic                     restart;   // strobe from RESET command or clear bit
   } chan_ctrl_t;

   typedef struct packed {
      logic [`TIMER_DATA_W-1:0] count;
      logic                     match;
   } chan_stat_t;

   // wishbone classic master signals
   typedef struct packed {
      logic                     cyc;
      logic                     stb;
      logic                     we;
      logic [`TIMER_ADDR_W-1:0] adr;
      logic [`TIMER_DATA_W-1:0] dat;
      logic [`TIMER_SEL_W-1:0]  sel;
   } wb_req_t;

   typedef struct packed {
      logic [`TIMER_DATA_W-1:0] dat;
      logic                     ack;
   } wb_rsp_t;

endpackage

//--- timer_regs.sv
`timescale 1ns/1ps
`include "timer_config.svh"

module timer_regs
   import timer_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_ni,

   input  wb_req_t    wb_req_i,
   output wb_rsp_t    wb_rsp_o,

   input  logic       event_lo_i,
   input  logic       event_hi_i,

   input  chan_stat_t stat_lo_i,
   input  chan_stat_t stat_hi_i,
   output chan_ctrl_t ctrl_lo_o,
   output chan_ctrl_t ctrl_hi_o,

   output logic       irq_lo_o,
   output logic       irq_hi_o,
   output logic       busy_o
);

   ack_state_e               ack_q;
   ack_state_e               ack_d;
   timer_cfg_t               cfg_lo_q;
   timer_cfg_t               cfg_lo_d;
   timer_cfg_t               cfg_hi_q;
   timer_cfg_t               cfg_hi_d;
   logic [`TIMER_DATA_W-1:0] cmp_lo_q;
   logic [`TIMER_DATA_W-1:0] cmp_hi_q;
   logic [`TIMER_DATA_W-1:0] rdata_q;
   logic [`TIMER_DATA_W-1:0] rd_word;
   reg_addr_e                addr;
   logic                     req_take;
   logic                     wr_en;
   logic                     wr_cfg_lo;
   logic                     wr_cfg_hi;
   logic                     wr_cmp_lo;
   logic                     wr_cmp_hi;
   logic                     load_lo;
   logic                     load_hi;
   logic                     start_lo;
   logic                     start_hi;
   logic                     reset_lo;
   logic                     reset_hi;

   // bus word to config, reserved bits forced to zero
   function automatic timer_cfg_t cfg_from_word(input logic [`TIMER_DATA_W-1:0] word);
      timer_cfg_t cfg;
      cfg         = timer_cfg_t'(word);
      cfg.rsvd_hi = '0;
      cfg.rsvd_7  = 1'b0;
      return cfg;
   endfunction

   // next config word of one channel
   function automatic timer_cfg_t cfg_next(
      input timer_cfg_t               cur,
      input logic                     wr,
      input logic [`TIMER_DATA_W-1:0] word,
      input logic                     start,
      input logic                     event_in,
      input logic                     match
   );
      timer_cfg_t nxt;
      nxt       = cur;
      nxt.clear = 1'b0;                     // held for one cycle only
      if (wr)
         nxt = cfg_from_word(word);
      // start and event win over one-shot stop, which wins over the bus value
      if (start || (event_in && cur.event_en))
         nxt.enable = 1'b1;
      else if (cur.one_shot && match)
         nxt.enable = 1'b0;
      return nxt;
   endfunction

   // ************************************************************
   // wishbone decode and ack
   // ************************************************************

   assign req_take = (ack_q == ACK_IDLE) && wb_req_i.cyc && wb_req_i.stb;
   assign wr_en    = req_take && wb_req_i.we && (wb_req_i.sel == '1);   // partial writes dropped
   assign addr     = reg_addr_e'(wb_req_i.adr);

   assign wr_cfg_lo = wr_en && (addr == CFG_LO);
   assign wr_cfg_hi = wr_en && (addr == CFG_HI);
   assign wr_cmp_lo = wr_en && (addr == CMP_LO);
   assign wr_cmp_hi = wr_en && (addr == CMP_HI);
   assign load_lo   = wr_en && (addr == VAL_LO);
   assign load_hi   = wr_en && (addr == VAL_HI);
   assign start_lo  = wr_en && (addr == START_LO);
   assign start_hi  = wr_en && (addr == START_HI);
   assign reset_lo  = wr_en && (addr == RESET_LO);
   assign reset_hi  = wr_en && (addr == RESET_HI);

   always_comb
   begin
      case (ack_q)
         ACK_IDLE: ack_d = req_take ? ACK_DONE : ACK_IDLE;
         default:  ack_d = ACK_IDLE;       // ack lasts one cycle
      endcase
   end

   // read mux, sampled on the edge that raises ack
   always_comb
   begin
      case (addr)
         CFG_LO:  rd_word = cfg_lo_q;
         CFG_HI:  rd_word = cfg_hi_q;
         VAL_LO:  rd_word = stat_lo_i.count;
         VAL_HI:  rd_word = stat_hi_i.count;
         CMP_LO:  rd_word = cmp_lo_q;
         CMP_HI:  rd_word = cmp_hi_q;
         default: rd_word = '0;            // START, RESET and unmapped
      endcase
   end

   // ************************************************************
   // configuration and compare registers
   // ************************************************************

   assign cfg_lo_d = cfg_next(cfg_lo_q, wr_cfg_lo, wb_req_i.dat, start_lo,
                              event_lo_i, stat_lo_i.match);
   assign cfg_hi_d = cfg_next(cfg_hi_q, wr_cfg_hi, wb_req_i.dat, start_hi,
                              event_hi_i, stat_hi_i.match);

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         ack_q    <= ACK_IDLE;
         cfg_lo_q <= '0;
         cfg_hi_q <= '0;
         cmp_lo_q <= '0;
         cmp_hi_q <= '0;
         rdata_q  <= '0;
      end
      else
      begin
         ack_q    <= ack_d;
         cfg_lo_q <= cfg_lo_d;
         cfg_hi_q <= cfg_hi_d;
         if (wr_cmp_lo)
            cmp_lo_q <= wb_req_i.dat;
         if (wr_cmp_hi)
            cmp_hi_q <= wb_req_i.dat;
         if (req_take && !wb_req_i.we)
            rdata_q <= rd_word;
      end
   end

   assign wb_rsp_o = '{dat: rdata_q, ack: (ack_q == ACK_DONE)};

   // channel control, strobes act on the edge that raises ack
   assign ctrl_lo_o = '{cfg:      cfg_lo_q,
                        cmp:      cmp_lo_q,
                        load:     load_lo,
                        load_val: wb_req_i.dat,
                        restart:  reset_lo | cfg_lo_q.clear};
   assign ctrl_hi_o = '{cfg:      cfg_hi_q,
                        cmp:      cmp_hi_q,
                        load:     load_hi,
                        load_val: wb_req_i.dat,
                        restart:  reset_hi | cfg_hi_q.clear};

   assign irq_lo_o = stat_lo_i.match & cfg_lo_q.irq_en;
   assign irq_hi_o = stat_hi_i.match & cfg_hi_q.irq_en;
   assign busy_o   = cfg_lo_q.enable | cfg_hi_q.enable;

endmodule

//--- timer_stim.txt
# columns: opcode address data expected, all hex; event and irq commands use address 0 lo, 1 hi
# opcodes: 0 write, 1 read, 2 idle, 3 event, 4 irq wait, 5 irq period, 6 read max, 7 read min, 8 read same, 9 read less, a busy, b no irq
0 00 fffffff0 0
1 00 0 0000ff70
0 04 abcd5a2c 0
1 04 0 00005a2c
0 10 12345678 0
1 10 0 12345678
0 14 deadbeef 0
1 14 0 deadbeef
0 00 2 0
1 00 0 0
1 18 0 0
1 24 0 0
0 04 0 0
0 08 1000 0
0 0c 500 0
2 0 14 0
1 08 0 1000
1 0c 0 500
0 10 9 0
0 20 0 0
0 00 355 0
5 0 0 28
6 08 0 9
0 00 0 0
0 20 0 0
0 10 4 0
0 00 35 0
4 0 40 0
1 00 0 34
a 0 0 0
1 08 0 0
2 0 14 0
8 08 0 0
b 0 30 0
0 00 0 0
0 08 100 0
3 0 0 0
2 0 5 0
1 08 0 100
0 00 8 0
3 0 0 0
2 0 a 0
1 00 0 9
1 0c 0 500
7 08 0 101
0 20 0 0
9 08 0 0
0 1c 0 0
1 04 0 1
7 0c 0 501
0 24 0 0
9 0c 0 0
0 00 0 0
0 04 0 0
a 0 0 0

//--- timer_unit.sv
`timescale 1ns/1ps
`include "timer_config.svh"

module timer_unit
   import timer_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_ni,

   // wishbone classic slave
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   input  logic                     wb_we_i,
   input  logic [`TIMER_ADDR_W-1:0] wb_adr_i,
   input  logic [`TIMER_DATA_W-1:0] wb_dat_i,
   input  logic [`TIMER_SEL_W-1:0]  wb_sel_i,
   output logic [`TIMER_DATA_W-1:0] wb_dat_o,
   output logic                     wb_ack_o,

   input  logic                     event_lo_i,
   input  logic                     event_hi_i,

   output logic                     irq_lo_o,
   output logic                     irq_hi_o,
   output logic                     busy_o
);

   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   chan_ctrl_t ctrl_lo;
   chan_ctrl_t ctrl_hi;
   chan_stat_t stat_lo;
   chan_stat_t stat_hi;

   assign wb_req = '{cyc: wb_cyc_i, stb: wb_stb_i, we: wb_we_i,
                     adr: wb_adr_i, dat: wb_dat_i, sel: wb_sel_i};

   assign wb_dat_o = wb_rsp.dat;
   assign wb_ack_o = wb_rsp.ack;

   timer_regs u_regs (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .wb_req_i   (wb_req),
      .wb_rsp_o   (wb_rsp),
      .event_lo_i (event_lo_i),
      .event_hi_i (event_hi_i),
      .stat_lo_i  (stat_lo),
      .stat_hi_i  (stat_hi),
      .ctrl_lo_o  (ctrl_lo),
      .ctrl_hi_o  (ctrl_hi),
      .irq_lo_o   (irq_lo_o),
      .irq_hi_o   (irq_hi_o),
      .busy_o     (busy_o)
   );

   timer_channel u_chan_lo (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .ctrl_i (ctrl_lo),
      .stat_o (stat_lo)
   );

   timer_channel u_chan_hi (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .ctrl_i (ctrl_hi),
      .stat_o (stat_hi)
   );

endmodule
